//--- Makefile
TOP := fetchTb

.PHONY: sim clean

sim:
	verilator --binary --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- compile.f
logic/fetchPkg.sv
logic/decodeIf.sv
logic/progCounter.sv
logic/instrMem.sv
logic/controlDecoder.sv
logic/hazardDetect.sv
logic/fetchStage.sv
verif/fetchChecker.sv
verif/fetchTb.sv

//--- logic/controlDecoder.sv
// Opcode control decoder
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
    input  fetchPkg::instrWord_t instr,
    decodeIf.decoder             ctl
);

    always_comb begin
        // Defaults describe a do-nothing word
        ctl.regWrite  = 1'b0;
        ctl.destSel   = fetchPkg::DEST_RD_I;
        ctl.memEnable = 1'b0;
        ctl.memWr     = 1'b0;
        ctl.val2Reg   = 1'b0;
        ctl.aluSel    = 1'b0;
        ctl.immSel    = fetchPkg::IMM_S5;
        ctl.linkReg   = fetchPkg::LINK_NONE;
        ctl.regJmp    = 1'b0;
        ctl.bFlag     = 1'b0;
        ctl.jFlag     = 1'b0;
        ctl.halt      = 1'b0;
        ctl.ctrlErr   = 1'b0;
        ctl.valid     = 1'b1;

        case (instr.r.opcode)
            fetchPkg::OP_HALT: begin
                ctl.halt = 1'b1;
            end
            fetchPkg::OP_NOP: begin
            end
            fetchPkg::OP_ADDI: begin
                ctl.regWrite = 1'b1;
                ctl.aluSel   = 1'b1;  // Immediate operand
            end
            fetchPkg::OP_LD: begin
                ctl.regWrite  = 1'b1;
                ctl.memEnable = 1'b1;
                ctl.val2Reg   = 1'b1;  // Write back memory data
                ctl.aluSel    = 1'b1;
            end
            fetchPkg::OP_ST: begin
                ctl.memEnable = 1'b1;
                ctl.memWr     = 1'b1;
                ctl.aluSel    = 1'b1;
            end
            fetchPkg::OP_ALU: begin
                ctl.regWrite = 1'b1;
                ctl.destSel  = fetchPkg::DEST_RD_R;
            end
            fetchPkg::OP_LBI: begin
                ctl.regWrite = 1'b1;
                ctl.destSel  = fetchPkg::DEST_RS;
                ctl.aluSel   = 1'b1;
                ctl.immSel   = fetchPkg::IMM_S8;
            end
            fetchPkg::OP_BEQZ: begin
                ctl.bFlag  = 1'b1;
                ctl.immSel = fetchPkg::IMM_S8;
            end
            fetchPkg::OP_J: begin
                ctl.jFlag  = 1'b1;
                ctl.immSel = fetchPkg::IMM_D11;
            end
            fetchPkg::OP_JR: begin
                ctl.jFlag  = 1'b1;
                ctl.regJmp = 1'b1;      // Target is rs + imm
                ctl.immSel = fetchPkg::IMM_S8;
            end
            fetchPkg::OP_JAL: begin
                ctl.jFlag    = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.linkReg  = fetchPkg::LINK_PC;
                ctl.destSel  = fetchPkg::DEST_R7;
                ctl.immSel   = fetchPkg::IMM_D11;
            end
            default: begin
                // Opcode outside the supported subset
                ctl.ctrlErr = 1'b1;
                ctl.valid   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/decodeIf.sv
// Decoder control bundle
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
    logic               regWrite;
    fetchPkg::destSel_e destSel;
    logic               memEnable;
    logic               memWr;
    logic               val2Reg;
    logic               aluSel;
    logic [2:0]         immSel;
    logic [1:0]         linkReg;
    logic               regJmp;
    logic               bFlag;
    logic               jFlag;
    logic               halt;
    logic               ctrlErr;
    logic               valid;

    modport decoder (
        output regWrite, destSel, memEnable, memWr, val2Reg, aluSel,
               immSel, linkReg, regJmp, bFlag, jFlag, halt, ctrlErr, valid
    );

    modport consumer (
        input regWrite, destSel, memEnable, memWr, val2Reg, aluSel,
              immSel, linkReg, regJmp, bFlag, jFlag, halt, ctrlErr, valid
    );
endinterface

`default_nettype wire

//--- logic/fetchPkg.sv
// Fetch stage definitions
`default_nettype none

package fetchPkg;

    localparam int DATA_W     = 16;
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);  // Word index width

    localparam logic [DATA_W-1:0] PC_STEP  = 16'd2;  // One halfword-aligned word
    localparam logic [DATA_W-1:0] NOP_WORD = 16'h0800;
    localparam logic [2:0]        LINK_REG_ADDR = 3'd7;

    // Immediate width selects for the execute stage
    localparam logic [2:0] IMM_S5  = 3'b000;
    localparam logic [2:0] IMM_S8  = 3'b010;
    localparam logic [2:0] IMM_D11 = 3'b100;

    localparam logic [1:0] LINK_NONE = 2'b00;
    localparam logic [1:0] LINK_PC   = 2'b01;  // Write back PC + 2

    typedef enum logic [4:0] {
        OP_HALT = 5'b00000,
        OP_NOP  = 5'b00001,
        OP_J    = 5'b00100,
        OP_JR   = 5'b00101,
        OP_JAL  = 5'b00110,
        OP_ADDI = 5'b01000,
        OP_BEQZ = 5'b01100,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_LBI  = 5'b11000,
        OP_ALU  = 5'b11011
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFormat_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm5;
    } iFormat_t;

    // Same word, field layout picked by opcode
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
    } instrWord_t;

    typedef enum logic [1:0] {
        DEST_RS   = 2'b00,  // Bits 10:8
        DEST_RD_R = 2'b01,  // Bits 4:2
        DEST_R7   = 2'b10,
        DEST_RD_I = 2'b11   // Bits 7:5
    } destSel_e;

endpackage

`default_nettype wire

//--- logic/fetchStage.sv
// Fetch stage top
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        pcSel,
    input  logic [fetchPkg::DATA_W-1:0] brnchAddr,
    input  logic [fetchPkg::DATA_W-1:0] rs,
    input  logic [fetchPkg::DATA_W-1:0] imm,
    input  logic                        imemWrEn,
    input  logic [fetchPkg::DATA_W-1:0] imemWrAddr,
    input  logic [fetchPkg::DATA_W-1:0] imemWrData,
    output logic [fetchPkg::DATA_W-1:0] pc,
    output logic [fetchPkg::DATA_W-1:0] instrC,
    output logic                        regWrite,
    output logic [2:0]                  writeRegAddr,
    output logic                        memEnable,
    output logic                        memWr,
    output logic                        val2Reg,
    output logic                        aluSel,
    output logic [2:0]                  immSel,
    output logic [1:0]                  linkReg,
    output logic                        regJmp,
    output logic                        bFlag,
    output logic                        jFlag,
    output logic                        halt,
    output logic                        ctrlErr
);

    fetchPkg::instrWord_t rawWord;
    fetchPkg::instrWord_t issuedWord;
    logic                 nopIns;
    logic                 pcStall;

    decodeIf issueCtl ();
    decodeIf checkCtl ();

    progCounter pcReg (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (pcStall),
        .halt      (issueCtl.halt),
        .pcSel     (pcSel),
        .brnchAddr (brnchAddr),
        .regJmp    (issueCtl.regJmp),
        .rs        (rs),
        .imm       (imm),
        .pc        (pc)
    );

    instrMem imem (
        .clk    (clk),
        .addr   (pc),
        .wrEn   (imemWrEn),
        .wrAddr (imemWrAddr),
        .wrData (imemWrData),
        .rdData (rawWord)
    );

    hazardDetect hazDet (
        .clk      (clk),
        .rstN     (rstN),
        .rawInstr (rawWord),
        .chk      (checkCtl),
        .issue    (issueCtl),
        .nop      (nopIns),
        .stall    (pcStall)
    );

    // Bubble replaces the fetched word on a load-use hit
    assign issuedWord = nopIns ? fetchPkg::NOP_WORD : rawWord;
    assign instrC     = issuedWord;

    controlDecoder mainDec (.instr(issuedWord), .ctl(issueCtl));
    controlDecoder chkDec  (.instr(rawWord),    .ctl(checkCtl));  // Raw word for hazards

    always_comb begin
        case (issueCtl.destSel)
            fetchPkg::DEST_RS:   writeRegAddr = issuedWord.i.rs;
            fetchPkg::DEST_RD_R: writeRegAddr = issuedWord.r.rd;
            fetchPkg::DEST_R7:   writeRegAddr = fetchPkg::LINK_REG_ADDR;
            fetchPkg::DEST_RD_I: writeRegAddr = issuedWord.i.rd;
        endcase
    end

    assign regWrite  = issueCtl.regWrite;
    assign memEnable = issueCtl.memEnable;
    assign memWr     = issueCtl.memWr;
    assign val2Reg   = issueCtl.val2Reg;
    assign aluSel    = issueCtl.aluSel;
    assign immSel    = issueCtl.immSel;
    assign linkReg   = issueCtl.linkReg;
    assign regJmp    = issueCtl.regJmp;
    assign bFlag     = issueCtl.bFlag;
    assign jFlag     = issueCtl.jFlag;
    assign halt      = issueCtl.halt;
    assign ctrlErr   = issueCtl.ctrlErr;

endmodule

`default_nettype wire

//--- logic/hazardDetect.sv
// Load-use hazard detection
`timescale 1ns/1ps
`default_nettype none

module hazardDetect (
    input  logic                 clk,
    input  logic                 rstN,
    input  fetchPkg::instrWord_t rawInstr,
    decodeIf.consumer            chk,
    decodeIf.consumer            issue,
    output logic                 nop,
    output logic                 stall
);

    logic       ldPending;  // Last issued word was a load
    logic [2:0] ldDest;
    logic       nopPrev;
    logic       readsRs;
    logic       readsRt;
    logic       useHit;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ldPending <= 1'b0;
            nopPrev   <= 1'b0;
        end else begin
            ldPending <= issue.memEnable & issue.val2Reg;
            nopPrev   <= nop;
        end
    end

    // Issued word equals the raw word whenever a load goes out
    always_ff @(posedge clk) begin
        ldDest <= rawInstr.i.rd;
    end

    assign readsRs = (rawInstr.i.rs == ldDest);

    // Bits 7:5 are a source only for ALU ops and stores
    assign readsRt = ((rawInstr.r.opcode == fetchPkg::OP_ALU) | (chk.memEnable & chk.memWr))
                     & (rawInstr.r.rt == ldDest);

    assign useHit = ldPending & chk.valid & (readsRs | readsRt);

    // One bubble at most, the held word issues next cycle
    assign nop   = useHit & ~nopPrev;
    assign stall = nop;

    // A bubble must reach the pipeline as a word with no side effects
    bubbleQuiet: assert property (
        @(posedge clk) disable iff (!rstN)
        nop |-> !issue.regWrite && !issue.memEnable && !issue.jFlag && !issue.halt
    ) else $error("bubble issued with side effects");

endmodule

`default_nettype wire

//--- logic/instrMem.sv
// Instruction memory
`timescale 1ns/1ps
`default_nettype none

module instrMem (
    input  logic                        clk,
    input  logic [fetchPkg::DATA_W-1:0] addr,
    input  logic                        wrEn,
    input  logic [fetchPkg::DATA_W-1:0] wrAddr,
    input  logic [fetchPkg::DATA_W-1:0] wrData,
    output logic [fetchPkg::DATA_W-1:0] rdData
);

    logic [fetchPkg::DATA_W-1:0]  mem [fetchPkg::IMEM_WORDS];
    logic [fetchPkg::IMEM_AW-1:0] rdIdx;
    logic [fetchPkg::IMEM_AW-1:0] wrIdx;

    // Byte addresses, one word per halfword pair
    assign rdIdx = addr[fetchPkg::IMEM_AW:1];
    assign wrIdx = wrAddr[fetchPkg::IMEM_AW:1];

    // Combinational read keeps fetch in one cycle
    assign rdData = mem[rdIdx];

    // Program load port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= wrData;
        end
    end

endmodule

`default_nettype wire

//--- logic/progCounter.sv
// Program counter
`timescale 1ns/1ps
`default_nettype none

module progCounter (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        stall,
    input  logic                        halt,
    input  logic                        pcSel,
    input  logic [fetchPkg::DATA_W-1:0] brnchAddr,
    input  logic                        regJmp,
    input  logic [fetchPkg::DATA_W-1:0] rs,
    input  logic [fetchPkg::DATA_W-1:0] imm,
    output logic [fetchPkg::DATA_W-1:0] pc
);

    logic [fetchPkg::DATA_W-1:0] pcNext;
    logic [fetchPkg::DATA_W-1:0] jmpTarget;

    assign jmpTarget = rs + imm;  // JR target

    // Highest priority first
    always_comb begin
        if (halt) begin
            pcNext = pc;
        end else if (stall) begin
            pcNext = pc;            // Load-use bubble
        end else if (pcSel) begin
            pcNext = brnchAddr;
        end else if (regJmp) begin
            pcNext = jmpTarget;
        end else begin
            pcNext = pc + fetchPkg::PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Targets from later stages must stay word aligned
    pcAligned: assert property (
        @(posedge clk) disable iff (!rstN) pc[0] == 1'b0
    ) else $error("pc misaligned: %h", pc);

endmodule

`default_nettype wire

//--- verif/fetchChecker.sv
// Fetch stage output checker
`timescale 1ns/1ps
`default_nettype none

module fetchChecker #(
    parameter int SAMPLE_OFS = 38  // Just ahead of the next rising edge
) (
    input  logic        clk,
    input  logic        checkEn,
    input  logic [3:0]  testId,
    input  logic [15:0] expPc,
    input  logic [15:0] expInstr,
    input  logic [2:0]  expWra,
    input  logic        expHalt,
    input  logic        expErr,
    input  logic [15:0] pc,
    input  logic [15:0] instrC,
    input  logic [2:0]  writeRegAddr,
    input  logic        halt,
    input  logic        ctrlErr,
    input  logic        regWrite,
    input  logic        memEnable,
    input  logic        memWr,
    input  logic        val2Reg,
    input  logic        aluSel,
    input  logic [2:0]  immSel,
    input  logic [1:0]  linkReg,
    input  logic        regJmp,
    input  logic        bFlag,
    input  logic        jFlag,
    output int          errCount,
    output int          recsSeen
);

    logic [3:0] curTest = '0;  // Zero until the first record
    int         testErrs = 0;
    int         testRecs = 0;
    int         testsRun = 0;
    int         testsFailed = 0;

    initial begin
        errCount = 0;
        recsSeen = 0;
    end

    task automatic checkField(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] test %0d record %0d: %s expected %h got %h",
                     curTest, recsSeen, name, exp, got);
            testErrs++;
            errCount++;
        end
    endtask

    task automatic noteFailure(input string what);
        $display("Test %0d record %0d: %s", curTest, recsSeen, what);
        testErrs++;
        errCount++;
    endtask

    // Control flags follow the opcode of the expected issued word
    task automatic compareControl(input logic [15:0] word);
        logic [4:0] op;
        logic       isLd;
        logic       isSt;
        logic       isJr;
        logic       isJal;
        logic       expWrite;
        op       = word[15:11];
        isLd     = (op == fetchPkg::OP_LD);
        isSt     = (op == fetchPkg::OP_ST);
        isJr     = (op == fetchPkg::OP_JR);
        isJal    = (op == fetchPkg::OP_JAL);
        expWrite = isLd | isJal | (op == fetchPkg::OP_ADDI) | (op == fetchPkg::OP_LBI)
                   | (op == fetchPkg::OP_ALU);
        checkField("regWrite", 16'(regWrite), 16'(expWrite));
        checkField("memEnable", 16'(memEnable), 16'(isLd | isSt));
        checkField("memWr", 16'(memWr), 16'(isSt));
        checkField("val2Reg", 16'(val2Reg), 16'(isLd));
        checkField("regJmp", 16'(regJmp), 16'(isJr));
        checkField("bFlag", 16'(bFlag), 16'(op == fetchPkg::OP_BEQZ));
        checkField("jFlag", 16'(jFlag), 16'(isJr | isJal | (op == fetchPkg::OP_J)));
        if (isJal) begin
            if (linkReg == 2'b00) begin
                noteFailure("linkReg not set for a JAL word");
            end
        end else begin
            checkField("linkReg", 16'(linkReg), 16'h0000);
        end
        if ($isunknown(aluSel) || $isunknown(immSel)) begin
            noteFailure("aluSel or immSel is unknown");
        end
    endtask

    task automatic closeTest();
        if (curTest != 4'd0) begin
            testsRun++;
            if (testErrs == 0) begin
                $display("Test %0d: %0d records, ok", curTest, testRecs);
            end else begin
                $display("Test %0d: %0d records, %0d mismatches", curTest, testRecs, testErrs);
                testsFailed++;
            end
        end
        testErrs = 0;
        testRecs = 0;
    endtask

    task automatic reportTotals();
        closeTest();
        curTest = '0;
        $display("Totals: %0d tests, %0d failed, %0d records, %0d mismatches",
                 testsRun, testsFailed, recsSeen, errCount);
    endtask

    always begin
        @(posedge clk);
        #SAMPLE_OFS;
        if (checkEn) begin
            if (testId != curTest) begin
                closeTest();
                curTest = testId;
            end
            checkField("pc", pc, expPc);
            checkField("instrC", instrC, expInstr);
            checkField("writeRegAddr", 16'(writeRegAddr), 16'(expWra));
            checkField("halt", 16'(halt), 16'(expHalt));
            checkField("ctrlErr", 16'(ctrlErr), 16'(expErr));
            compareControl(expInstr);
            testRecs++;
            recsSeen++;
        end
    end

endmodule

`default_nettype wire

//--- verif/fetchTb.sv
// Fetch stage testbench
`timescale 1ns/1ps
`default_nettype none

module fetchTb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 5;
    localparam int REC_BASE     = 64;  // First record entry in the vectors file

    logic        clk;
    logic        rstN;
    logic        pcSel;
    logic [15:0] brnchAddr;
    logic [15:0] rs;
    logic [15:0] imm;
    logic        imemWrEn;
    logic [15:0] imemWrAddr;
    logic [15:0] imemWrData;
    logic [15:0] pc;
    logic [15:0] instrC;
    logic [2:0]  writeRegAddr;
    logic [2:0]  immSel;
    logic [1:0]  linkReg;
    logic        regWrite, memEnable, memWr, val2Reg, aluSel;
    logic        regJmp, bFlag, jFlag, halt, ctrlErr;

    logic        checkEn;
    logic [3:0]  testId;
    logic [15:0] expPc;
    logic [15:0] expInstr;
    logic [2:0]  expWra;
    logic        expHalt;
    logic        expErr;
    int          errCount;
    int          recsSeen;

    logic [99:0] vecMem [128];
    int          progWords;
    int          numRecs;
    int          cycleCount = 0;
    int          cycleLimit = 1000;

    fetchStage dut0 (.*);

    fetchChecker #(.SAMPLE_OFS(CLK_PERIOD - 2)) chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #1;  // Limit is known once the vectors are read
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [99:0] rec;
        int          i;
        rstN = 1'b0;
        pcSel = 1'b0;
        brnchAddr = '0;
        rs = '0;
        imm = '0;
        imemWrEn = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        checkEn = 1'b0;
        testId = '0;
        expPc = '0;
        expInstr = '0;
        expWra = '0;
        expHalt = 1'b0;
        expErr = 1'b0;

        $readmemh("verif/fetchVectors.txt", vecMem);
        progWords  = int'(vecMem[0][31:16]);
        numRecs    = int'(vecMem[0][15:0]);
        cycleLimit = progWords + numRecs + RESET_CYCLES + 20;

        // Program load while still in reset
        for (i = 0; i < progWords; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            imemWrEn   = 1'b1;
            imemWrAddr = 16'(2 * i);
            imemWrData = vecMem[1 + i][15:0];
        end
        @(posedge clk);
        #DRIVE_DLY;
        imemWrEn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);

        for (i = 0; i < numRecs; i++) begin
            #DRIVE_DLY;
            rec       = vecMem[REC_BASE + i];
            rstN      = 1'b1;
            checkEn   = 1'b1;
            testId    = rec[99:96];
            pcSel     = rec[92];
            brnchAddr = rec[91:76];
            rs        = rec[75:60];
            imm       = rec[59:44];
            expPc     = rec[43:28];
            expInstr  = rec[27:12];
            expWra    = rec[10:8];
            expHalt   = rec[4];
            expErr    = rec[0];
            @(posedge clk);
        end
        #DRIVE_DLY;
        checkEn = 1'b0;

        chk0.reportTotals();
        if (recsSeen != numRecs || numRecs == 0) begin
            $display("Checker sampled %0d of %0d records", recsSeen, numRecs);
        end
        if (errCount == 0 && recsSeen == numRecs && numRecs > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/fetchVectors.txt
// @00 header: program word count, record count. @01 on: program words, word n at byte 2n
// @40 on, one record per cycle: test pcSel brnchAddr rs imm | pc instrC writeRegAddr halt ctrlErr
@00
0016_0014
@01
4145 D950 42A1 8960 DB38 8A82 41E3 8940
8548 0800 0800 0800 0800 0800 0800 0800
2800 0000 3005 C355 F800 0000
@40
1_0_0000_0000_0000_0000_4145_2_0_0
1_0_0000_0000_0000_0002_D950_4_0_0
1_0_0000_0000_0000_0004_42A1_5_0_0
2_0_0000_0000_0000_0006_8960_3_0_0
2_0_0000_0000_0000_0008_0800_0_0_0
2_0_0000_0000_0000_0008_DB38_6_0_0
2_0_0000_0000_0000_000A_8A82_4_0_0
2_0_0000_0000_0000_000C_41E3_7_0_0
2_0_0000_0000_0000_000E_8940_2_0_0
2_0_0000_0000_0000_0010_0800_0_0_0
2_0_0000_0000_0000_0010_8548_2_0_0
3_1_0020_0000_0000_0012_0800_0_0_0
3_0_0000_0010_0014_0020_2800_0_0_0
3_0_0000_0000_0000_0024_3005_7_0_0
3_0_0000_0000_0000_0026_C355_3_0_0
4_0_0000_0000_0000_0028_F800_0_0_1
5_0_0000_0000_0000_002A_0000_0_1_0
5_1_0000_0000_0000_002A_0000_0_1_0
5_0_0000_0000_0000_002A_0000_0_1_0
5_0_0000_0000_0000_002A_0000_0_1_0
